//--- hw/axiReadMaster.sv
`timescale 1ns/1ns

module axiReadMaster (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             rdReq,
   input  ringPkg::axiAddrT rdAddr,
   output logic             rdDone,
   output ringPkg::axiDataT rdData,
   output logic             rdErr,
   output ringPkg::axiAddrT araddr,
   output logic             arvalid,
   input  logic             arready,
   input  ringPkg::axiDataT rdata,
   input  ringPkg::axiRespT rresp,
   input  logic             rvalid,
   output logic             rready
);
   import ringPkg::*;

   typedef enum logic [1:0] {RdIdle, RdAddr, RdData} rdStateT;

   rdStateT state;

   assign arvalid = (state == RdAddr);
   assign rready  = (state == RdData);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state  <= RdIdle;
         rdDone <= 1'b0;
         rdErr  <= 1'b0;
      end else begin
         rdDone <= 1'b0;
         case (state)
            // rdDone still high means the controller has not dropped rdReq yet
            RdIdle: if (rdReq && !rdDone) state <= RdAddr;
            RdAddr: if (arready) state <= RdData;
            RdData: begin
               if (rvalid) begin
                  rdDone <= 1'b1;
                  rdErr  <= (rresp != RespOkay);
                  state  <= RdIdle;
               end
            end
            default: state <= RdIdle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == RdIdle && rdReq) begin
         araddr <= rdAddr;
      end
      if (rvalid && rready) begin
         rdData <= rdata;
      end
   end

endmodule

//--- hw/axiWriteMaster.sv
`timescale 1ns/1ns

module axiWriteMaster (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             wrReq,
   input  ringPkg::axiAddrT wrAddr,
   input  ringPkg::axiDataT wrData,
   output logic             wrDone,
   output logic             wrErr,
   output ringPkg::axiAddrT awaddr,
   output logic             awvalid,
   input  logic             awready,
   output ringPkg::axiDataT wdata,
   output logic [15:0]      wstrb,
   output logic             wvalid,
   input  logic             wready,
   input  ringPkg::axiRespT bresp,
   input  logic             bvalid,
   output logic             bready
);
   import ringPkg::*;

   typedef enum logic [1:0] {WrIdle, WrSend, WrResp} wrStateT;

   wrStateT state;
   logic    awSent;
   logic    wSent;
   logic    awFin;
   logic    wFin;

   // Address and data channels complete in either order
   assign awvalid = (state == WrSend) && !awSent;
   assign wvalid  = (state == WrSend) && !wSent;
   assign bready  = (state == WrResp);
   assign wstrb   = '1;

   assign awFin = awSent || awready;
   assign wFin  = wSent || wready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state  <= WrIdle;
         awSent <= 1'b0;
         wSent  <= 1'b0;
         wrDone <= 1'b0;
         wrErr  <= 1'b0;
      end else begin
         wrDone <= 1'b0;
         case (state)
            WrIdle: begin
               if (wrReq && !wrDone) begin
                  awSent <= 1'b0;
                  wSent  <= 1'b0;
                  state  <= WrSend;
               end
            end
            WrSend: begin
               awSent <= awFin;
               wSent  <= wFin;
               if (awFin && wFin) state <= WrResp;
            end
            WrResp: begin
               if (bvalid) begin
                  wrDone <= 1'b1;
                  wrErr  <= (bresp != RespOkay);
                  state  <= WrIdle;
               end
            end
            default: state <= WrIdle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == WrIdle && wrReq) begin
         awaddr <= wrAddr;
         wdata  <= wrData;
      end
   end

endmodule

//--- hw/inboundBuffer.sv
`timescale 1ns/1ns

module inboundBuffer #(
   parameter int  BufDepth = 16,
   localparam int IdxW     = $clog2(BufDepth)
) (
   input  logic            clk,
   input  logic            bufWrEn,
   input  logic [IdxW-1:0] bufWrAddr,
   input  ringPkg::entryT  bufWrData,
   input  logic [IdxW-1:0] bufRdAddr,
   output ringPkg::entryT  bufRdData
);
   import ringPkg::*;

   entryT mem [BufDepth];

   always_ff @(posedge clk) begin
      if (bufWrEn) begin
         mem[bufWrAddr] <= bufWrData;
      end
      bufRdData <= mem[bufRdAddr];
   end

endmodule

//--- hw/ringDmaTop.sv
`timescale 1ns/1ns

module ringDmaTop #(
   parameter int BufDepth = 16
) (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             cyc,
   input  logic             stb,
   input  logic             we,
   input  ringPkg::wbAddrT  adr,
   input  ringPkg::entryT   datWr,
   output ringPkg::entryT   datRd,
   output logic             ack,
   output ringPkg::axiAddrT araddr,
   output logic             arvalid,
   input  logic             arready,
   input  ringPkg::axiDataT rdata,
   input  ringPkg::axiRespT rresp,
   input  logic             rvalid,
   output logic             rready,
   output ringPkg::axiAddrT awaddr,
   output logic             awvalid,
   input  logic             awready,
   output ringPkg::axiDataT wdata,
   output logic [15:0]      wstrb,
   output logic             wvalid,
   input  logic             wready,
   input  ringPkg::axiRespT bresp,
   input  logic             bvalid,
   output logic             bready
);
   import ringPkg::*;

   localparam int IdxW = $clog2(BufDepth);
   localparam int CntW = $clog2(BufDepth + 1);

   logic            rdReq;
   axiAddrT         rdAddr;
   logic            rdDone;
   axiDataT         rdData;
   logic            rdErr;
   logic            wrReq;
   axiAddrT         wrAddr;
   axiDataT         wrData;
   logic            wrDone;
   logic            wrErr;
   logic            enable;
   logic            doneFlag;
   entryT           pollPeriod;
   entryT           ringBase;
   entryT           ptrAddr;
   entryT           doorbellAddr;
   logic            setDone;
   logic            setReadErr;
   logic [CntW-1:0] entryCount;
   slotIdxT         consumerSlot;
   logic            bufWrEn;
   logic [IdxW-1:0] bufWrAddr;
   entryT           bufWrData;
   logic [IdxW-1:0] bufRdAddr;
   entryT           bufRdData;

   axiReadMaster uRdMaster (
      .clk     (clk),
      .rst_n   (rst_n),
      .rdReq   (rdReq),
      .rdAddr  (rdAddr),
      .rdDone  (rdDone),
      .rdData  (rdData),
      .rdErr   (rdErr),
      .araddr  (araddr),
      .arvalid (arvalid),
      .arready (arready),
      .rdata   (rdata),
      .rresp   (rresp),
      .rvalid  (rvalid),
      .rready  (rready)
   );

   axiWriteMaster uWrMaster (
      .clk     (clk),
      .rst_n   (rst_n),
      .wrReq   (wrReq),
      .wrAddr  (wrAddr),
      .wrData  (wrData),
      .wrDone  (wrDone),
      .wrErr   (wrErr),
      .awaddr  (awaddr),
      .awvalid (awvalid),
      .awready (awready),
      .wdata   (wdata),
      .wstrb   (wstrb),
      .wvalid  (wvalid),
      .wready  (wready),
      .bresp   (bresp),
      .bvalid  (bvalid),
      .bready  (bready)
   );

   ringFetchCtrl #(.BufDepth(BufDepth)) uCtrl (
      .clk          (clk),
      .rst_n        (rst_n),
      .enable       (enable),
      .doneFlag     (doneFlag),
      .pollPeriod   (pollPeriod),
      .ringBase     (ringBase),
      .ptrAddr      (ptrAddr),
      .doorbellAddr (doorbellAddr),
      .rdReq        (rdReq),
      .rdAddr       (rdAddr),
      .rdDone       (rdDone),
      .rdData       (rdData),
      .rdErr        (rdErr),
      .wrReq        (wrReq),
      .wrAddr       (wrAddr),
      .wrData       (wrData),
      .wrDone       (wrDone),
      .wrErr        (wrErr),
      .bufWrEn      (bufWrEn),
      .bufWrAddr    (bufWrAddr),
      .bufWrData    (bufWrData),
      .setDone      (setDone),
      .setReadErr   (setReadErr),
      .entryCount   (entryCount),
      .consumerSlot (consumerSlot)
   );

   ringRegs #(.BufDepth(BufDepth)) uRegs (
      .clk          (clk),
      .rst_n        (rst_n),
      .cyc          (cyc),
      .stb          (stb),
      .we           (we),
      .adr          (adr),
      .datWr        (datWr),
      .datRd        (datRd),
      .ack          (ack),
      .enable       (enable),
      .pollPeriod   (pollPeriod),
      .ringBase     (ringBase),
      .ptrAddr      (ptrAddr),
      .doorbellAddr (doorbellAddr),
      .doneFlag     (doneFlag),
      .setDone      (setDone),
      .setReadErr   (setReadErr),
      .entryCount   (entryCount),
      .consumerSlot (consumerSlot),
      .bufRdAddr    (bufRdAddr),
      .bufRdData    (bufRdData)
   );

   inboundBuffer #(.BufDepth(BufDepth)) uBuffer (
      .clk       (clk),
      .bufWrEn   (bufWrEn),
      .bufWrAddr (bufWrAddr),
      .bufWrData (bufWrData),
      .bufRdAddr (bufRdAddr),
      .bufRdData (bufRdData)
   );

endmodule

//--- hw/ringFetchCtrl.sv
`timescale 1ns/1ns

module ringFetchCtrl #(
   parameter int  BufDepth = 16,
   localparam int IdxW     = $clog2(BufDepth),
   localparam int CntW     = $clog2(BufDepth + 1)
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              enable,
   input  logic              doneFlag,
   input  ringPkg::entryT    pollPeriod,
   input  ringPkg::entryT    ringBase,
   input  ringPkg::entryT    ptrAddr,
   input  ringPkg::entryT    doorbellAddr,
   output logic              rdReq,
   output ringPkg::axiAddrT  rdAddr,
   input  logic              rdDone,
   input  ringPkg::axiDataT  rdData,
   input  logic              rdErr,
   output logic              wrReq,
   output ringPkg::axiAddrT  wrAddr,
   output ringPkg::axiDataT  wrData,
   input  logic              wrDone,
   input  logic              wrErr,
   output logic              bufWrEn,
   output logic [IdxW-1:0]   bufWrAddr,
   output ringPkg::entryT    bufWrData,
   output logic              setDone,
   output logic              setReadErr,
   output logic [CntW-1:0]   entryCount,
   output ringPkg::slotIdxT  consumerSlot
);
   import ringPkg::*;

   typedef enum logic [2:0] {StIdle, StLoadPtr, StFetch, StDoorbell, StDone} ctrlStateT;

   ctrlStateT       state;
   entryT           pollCnt;
   logic [IdxW-1:0] entryIdx;
   slotIdxT         prodSlot;
   slotIdxT         nextSlot;
   logic            lastEntry;

   // Slot address is ring base plus slot in bits 14:12 plus entry offset
   function automatic axiAddrT entryAddr(input logic [IdxW-1:0] idx);
      entryAddr = axiAddrT'(ringBase) + (axiAddrT'(consumerSlot) << SlotLsb)
                + axiAddrT'(idx) * EntryStride;
   endfunction

   assign prodSlot  = slotIdxT'(rdData >> SlotLsb);
   assign nextSlot  = consumerSlot + 3'd1;
   assign lastEntry = (rdData[31:0] == Terminator) || (entryIdx == IdxW'(BufDepth - 1));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state        <= StIdle;
         pollCnt      <= '0;
         entryIdx     <= '0;
         rdReq        <= 1'b0;
         rdAddr       <= '0;
         wrReq        <= 1'b0;
         wrAddr       <= '0;
         wrData       <= '0;
         bufWrEn      <= 1'b0;
         setDone      <= 1'b0;
         setReadErr   <= 1'b0;
         entryCount   <= '0;
         consumerSlot <= '0;
      end else begin
         bufWrEn    <= 1'b0;
         setDone    <= 1'b0;
         setReadErr <= 1'b0;
         if (state != StIdle) pollCnt <= '0;
         case (state)
            StIdle: begin
               if (!enable || doneFlag) begin
                  pollCnt <= '0;
               end else if (pollCnt >= pollPeriod) begin
                  rdReq  <= 1'b1;
                  rdAddr <= axiAddrT'(ptrAddr);
                  state  <= StLoadPtr;
               end else begin
                  pollCnt <= pollCnt + 1'b1;
               end
            end
            StLoadPtr: begin
               if (rdDone) begin
                  rdReq <= 1'b0;
                  if (rdErr) begin
                     setReadErr <= 1'b1;
                     state      <= StIdle;
                  end else if (prodSlot != consumerSlot) begin
                     entryIdx   <= '0;
                     entryCount <= '0;
                     rdReq      <= 1'b1;
                     rdAddr     <= entryAddr('0);
                     state      <= StFetch;
                  end else begin
                     state <= StIdle;
                  end
               end
            end
            StFetch: begin
               if (rdDone) begin
                  rdReq <= 1'b0;
                  if (rdErr) begin
                     setReadErr <= 1'b1;
                     state      <= StIdle;
                  end else begin
                     bufWrEn    <= 1'b1;
                     bufWrAddr  <= entryIdx;
                     bufWrData  <= rdData[31:0];
                     entryCount <= CntW'(entryIdx + 1);
                     if (lastEntry) begin
                        wrReq  <= 1'b1;
                        wrAddr <= axiAddrT'(doorbellAddr);
                        wrData <= axiDataT'(nextSlot) << SlotLsb;
                        state  <= StDoorbell;
                     end else begin
                        entryIdx <= entryIdx + 1'b1;
                        rdReq    <= 1'b1;
                        rdAddr   <= entryAddr(entryIdx + 1'b1);
                     end
                  end
               end
            end
            StDoorbell: begin
               // On error wrReq stays high and the master reissues the write
               if (wrDone && !wrErr) begin
                  wrReq        <= 1'b0;
                  consumerSlot <= nextSlot;
                  setDone      <= 1'b1;
                  state        <= StDone;
               end
            end
            StDone: begin
               if (!doneFlag && !setDone) state <= StIdle;
            end
            default: state <= StIdle;
         endcase
      end
   end

endmodule

//--- hw/ringPkg.sv
package ringPkg;

   // Bus widths
   typedef logic [63:0]  axiAddrT;
   typedef logic [127:0] axiDataT;
   typedef logic [1:0]   axiRespT;

   // Buffer entries and Wishbone register data share one width
   typedef logic [31:0]  entryT;
   typedef logic [5:0]   wbAddrT;

   // Eight ring slots
   typedef logic [2:0]   slotIdxT;

   localparam axiRespT RespOkay = 2'b00;

   // Slot field position in pointer words and in ring addresses
   localparam int SlotLsb = 12;

   // Byte step between 128-bit ring entries
   localparam axiAddrT EntryStride = 64'h10;

   // Last entry of a slot
   localparam entryT Terminator = 32'h63;

endpackage

//--- hw/ringRegs.sv
`timescale 1ns/1ns

module ringRegs #(
   parameter int  BufDepth = 16,
   localparam int IdxW     = $clog2(BufDepth),
   localparam int CntW     = $clog2(BufDepth + 1)
) (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             cyc,
   input  logic             stb,
   input  logic             we,
   input  ringPkg::wbAddrT  adr,
   input  ringPkg::entryT   datWr,
   output ringPkg::entryT   datRd,
   output logic             ack,
   output logic             enable,
   output ringPkg::entryT   pollPeriod,
   output ringPkg::entryT   ringBase,
   output ringPkg::entryT   ptrAddr,
   output ringPkg::entryT   doorbellAddr,
   output logic             doneFlag,
   input  logic             setDone,
   input  logic             setReadErr,
   input  logic [CntW-1:0]  entryCount,
   input  ringPkg::slotIdxT consumerSlot,
   output logic [IdxW-1:0]  bufRdAddr,
   input  ringPkg::entryT   bufRdData
);
   import ringPkg::*;

   localparam wbAddrT AdrControl  = 6'd0;
   localparam wbAddrT AdrPoll     = 6'd1;
   localparam wbAddrT AdrRingBase = 6'd2;
   localparam wbAddrT AdrPtr      = 6'd3;
   localparam wbAddrT AdrDoorbell = 6'd4;
   localparam wbAddrT AdrStatus   = 6'd5;

   logic  readErr;
   logic  wrStrobe;
   logic  clrStatus;
   entryT regRd;

   assign wrStrobe  = cyc && stb && we && !ack;
   assign clrStatus = wrStrobe && (adr == AdrStatus);

   // Window address goes straight to the RAM so data arrives with ack
   assign bufRdAddr = adr[IdxW-1:0];
   assign datRd     = adr[5] ? bufRdData : regRd;

   always_comb begin
      case (adr)
         AdrControl:  regRd = {31'b0, enable};
         AdrPoll:     regRd = pollPeriod;
         AdrRingBase: regRd = ringBase;
         AdrPtr:      regRd = ptrAddr;
         AdrDoorbell: regRd = doorbellAddr;
         AdrStatus:   regRd = {13'b0, consumerSlot, 8'(entryCount), 6'b0, readErr, doneFlag};
         default:     regRd = '0;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ack          <= 1'b0;
         enable       <= 1'b0;
         pollPeriod   <= '0;
         ringBase     <= '0;
         ptrAddr      <= '0;
         doorbellAddr <= '0;
         doneFlag     <= 1'b0;
         readErr      <= 1'b0;
      end else begin
         ack <= cyc && stb && !ack;
         if (wrStrobe) begin
            case (adr)
               AdrControl:  enable       <= datWr[0];
               AdrPoll:     pollPeriod   <= datWr;
               AdrRingBase: ringBase     <= datWr;
               AdrPtr:      ptrAddr      <= datWr;
               AdrDoorbell: doorbellAddr <= datWr;
               default: ;
            endcase
         end
         // Set wins over write-1-to-clear
         if (setDone) doneFlag <= 1'b1;
         else if (clrStatus && datWr[0]) doneFlag <= 1'b0;
         if (setReadErr) readErr <= 1'b1;
         else if (clrStatus && datWr[1]) readErr <= 1'b0;
      end
   end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the ring fetcher testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary -Wno-fatal --top-module ringDmaTb -f sources.f \
   -Mdir obj_dir -o ringDmaSim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
   cat "$BUILD_LOG"
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/ringDmaSim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -q "Simulation FAILED" "$SIM_LOG"; then
   exit 1
fi
if [ $sim_status -ne 0 ]; then
   echo "Simulator exited with status $sim_status"
   exit 1
fi
exit 0

//--- sources.f
hw/ringPkg.sv
hw/inboundBuffer.sv
hw/axiReadMaster.sv
hw/axiWriteMaster.sv
hw/ringFetchCtrl.sv
hw/ringRegs.sv
hw/ringDmaTop.sv
verif/tbClock.sv
verif/axiHostMem.sv
verif/ringDmaTb.sv

//--- verif/axiHostMem.sv
`timescale 1ns/1ns

module axiHostMem (
   input  logic             clk,
   input  logic             rst_n,
   input  ringPkg::axiAddrT araddr,
   input  logic             arvalid,
   output logic             arready,
   output ringPkg::axiDataT rdata,
   output ringPkg::axiRespT rresp,
   output logic             rvalid,
   input  logic             rready,
   input  ringPkg::axiAddrT awaddr,
   input  logic             awvalid,
   output logic             awready,
   input  ringPkg::axiDataT wdata,
   input  logic [15:0]      wstrb,
   input  logic             wvalid,
   output logic             wready,
   output ringPkg::axiRespT bresp,
   output logic             bvalid,
   input  logic             bready,
   input  ringPkg::axiAddrT rdErrAddr,
   input  logic             rdErrEn,
   input  logic             wrErrEn
);
   import ringPkg::*;

   localparam axiRespT RespSlvErr = 2'b10;

   // Sparse host memory with one 128-bit word per aligned address
   axiDataT     mem [axiAddrT];
   int          wrCount;
   axiAddrT     rAddr;
   axiAddrT     wAddr;
   axiDataT     wBuf;
   logic [15:0] wStrbBuf;
   logic        rPend;
   logic        awGot;
   logic        wGot;
   logic        wrErrUsed;
   int unsigned arWait;
   int unsigned rWait;
   int unsigned awWait;
   int unsigned wWait;

   // Unwritten words return a pattern built from the whole address
   function automatic axiDataT readWord(input axiAddrT a);
      if (mem.exists(a)) begin
         return mem[a];
      end
      return {~a, a};
   endfunction

   // Only byte lanes with a strobe bit take the new data
   function automatic axiDataT mergeBytes(input axiDataT old, input axiDataT nw,
                                          input logic [15:0] strb);
      axiDataT w;
      w = old;
      for (int b = 0; b < 16; b++) begin
         if (strb[b]) w[8*b +: 8] = nw[8*b +: 8];
      end
      return w;
   endfunction

   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         arready <= 1'b0;
         rvalid  <= 1'b0;
         rresp   <= RespOkay;
         rdata   <= '0;
         rAddr   <= '0;
         rPend   <= 1'b0;
         arWait  <= 0;
         rWait   <= 0;
      end else begin
         arready <= 1'b0;
         if (rvalid && rready) rvalid <= 1'b0;
         if (arvalid && arready) begin
            rAddr  <= araddr;
            rPend  <= 1'b1;
            rWait  <= $urandom % 4;
            arWait <= $urandom % 4;
         end else if (arvalid && !rPend && !rvalid) begin
            if (arWait == 0) arready <= 1'b1;
            else arWait <= arWait - 1;
         end
         if (rPend) begin
            if (rWait == 0) begin
               rvalid <= 1'b1;
               rdata  <= readWord(rAddr);
               rresp  <= (rdErrEn && rAddr == rdErrAddr) ? RespSlvErr : RespOkay;
               rPend  <= 1'b0;
            end else begin
               rWait <= rWait - 1;
            end
         end
      end
   end

   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         awready   <= 1'b0;
         wready    <= 1'b0;
         bvalid    <= 1'b0;
         bresp     <= RespOkay;
         awGot     <= 1'b0;
         wGot      <= 1'b0;
         wrErrUsed <= 1'b0;
         wrCount   <= 0;
         awWait    <= 0;
         wWait     <= 0;
      end else begin
         awready <= 1'b0;
         wready  <= 1'b0;
         if (bvalid && bready) bvalid <= 1'b0;
         if (awvalid && awready) begin
            awGot  <= 1'b1;
            wAddr  <= awaddr;
            awWait <= $urandom % 4;
         end else if (awvalid && !awGot) begin
            if (awWait == 0) awready <= 1'b1;
            else awWait <= awWait - 1;
         end
         if (wvalid && wready) begin
            wGot     <= 1'b1;
            wBuf     <= wdata;
            wStrbBuf <= wstrb;
            wWait    <= $urandom % 4;
         end else if (wvalid && !wGot) begin
            if (wWait == 0) wready <= 1'b1;
            else wWait <= wWait - 1;
         end
         if (awGot && wGot && !bvalid) begin
            awGot   <= 1'b0;
            wGot    <= 1'b0;
            bvalid  <= 1'b1;
            wrCount <= wrCount + 1;
            // One SLVERR per enable and nothing stored
            if (wrErrEn && !wrErrUsed) begin
               bresp     <= RespSlvErr;
               wrErrUsed <= 1'b1;
            end else begin
               bresp      <= RespOkay;
               mem[wAddr] = mergeBytes(readWord(wAddr), wBuf, wStrbBuf);
            end
         end
         if (!wrErrEn) wrErrUsed <= 1'b0;
      end
   end

endmodule

//--- verif/ringDmaTb.sv
`timescale 1ns/1ns

module ringDmaTb;
   import ringPkg::*;

   localparam int     BufDepth     = 16;
   localparam int     PollPeriod   = 24;
   localparam int     WaitLimit    = 2000;
   localparam entryT  RingBase     = 32'h0001_0000;
   localparam entryT  PtrAddr      = 32'h0002_0000;
   localparam entryT  DoorbellAddr = 32'h0002_0100;
   localparam wbAddrT AdrControl   = 6'd0;
   localparam wbAddrT AdrStatus    = 6'd5;
   localparam wbAddrT AdrWindow    = 6'd32;

   typedef struct packed {
      slotIdxT    prodSlot;
      logic [7:0] nData;
      logic       hasTerm;
      logic       wrErr;
      logic       rdErr;
      logic [7:0] errIdx;
   } scenT;

   // Producer slot, data entries, terminator, doorbell error, entry read error, error index
   localparam int   NumScen = 10;
   localparam scenT Scenarios [NumScen] = '{
      '{3'd3, 8'd4,  1'b1, 1'b0, 1'b0, 8'd0},
      '{3'd1, 8'd0,  1'b0, 1'b0, 1'b0, 8'd0},
      '{3'd5, 8'd20, 1'b0, 1'b0, 1'b0, 8'd0},
      '{3'd6, 8'd2,  1'b1, 1'b1, 1'b0, 8'd0},
      '{3'd0, 8'd0,  1'b1, 1'b0, 1'b0, 8'd0},
      '{3'd2, 8'd7,  1'b1, 1'b0, 1'b0, 8'd0},
      '{3'd1, 8'd15, 1'b1, 1'b0, 1'b0, 8'd0},
      '{3'd4, 8'd1,  1'b1, 1'b0, 1'b0, 8'd0},
      '{3'd3, 8'd3,  1'b1, 1'b0, 1'b0, 8'd0},
      '{3'd2, 8'd5,  1'b1, 1'b0, 1'b1, 8'd2}
   };

   logic        clk;
   logic        rst_n;
   logic        cyc;
   logic        stb;
   logic        we;
   wbAddrT      adr;
   entryT       datWr;
   entryT       datRd;
   logic        ack;
   axiAddrT     araddr;
   logic        arvalid;
   logic        arready;
   axiDataT     rdata;
   axiRespT     rresp;
   logic        rvalid;
   logic        rready;
   axiAddrT     awaddr;
   logic        awvalid;
   logic        awready;
   axiDataT     wdata;
   logic [15:0] wstrb;
   logic        wvalid;
   logic        wready;
   axiRespT     bresp;
   logic        bvalid;
   logic        bready;
   axiAddrT     rdErrAddr;
   logic        rdErrEn;
   logic        wrErrEn;
   slotIdxT     expSlot;
   int          wrBefore;
   entryT       rdVal;

   tbClock clkGen (.clk(clk));

   axiHostMem hostMem (
      .clk(clk), .rst_n(rst_n),
      .araddr(araddr), .arvalid(arvalid), .arready(arready),
      .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
      .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
      .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
      .bresp(bresp), .bvalid(bvalid), .bready(bready),
      .rdErrAddr(rdErrAddr), .rdErrEn(rdErrEn), .wrErrEn(wrErrEn)
   );

   ringDmaTop #(.BufDepth(BufDepth)) dut (
      .clk(clk), .rst_n(rst_n),
      .cyc(cyc), .stb(stb), .we(we), .adr(adr), .datWr(datWr), .datRd(datRd), .ack(ack),
      .araddr(araddr), .arvalid(arvalid), .arready(arready),
      .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
      .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
      .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
      .bresp(bresp), .bvalid(bvalid), .bready(bready)
   );

   task automatic failRun(input string msg);
      $display("%s", msg);
      $display("Simulation FAILED");
      $fatal(1, "Stopped at first error");
   endtask

   task automatic checkEntry(input string what, input entryT got, input entryT exp);
      if (got !== exp) begin
         failRun($sformatf("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp));
      end
   endtask

   task automatic checkSlot(input string what, input slotIdxT got, input slotIdxT exp);
      if (got !== exp) begin
         failRun($sformatf("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp));
      end
   endtask

   task automatic checkFlag(input string what, input bit got, input bit exp);
      if (got !== exp) begin
         failRun($sformatf("** Error at %0t ns: %s is %0b, expected %0b", $time, what, got, exp));
      end
   endtask

   task automatic busCycle(input logic write, input wbAddrT a, input entryT d, output entryT q);
      int n;
      n = 0;
      @(posedge clk);
      #2;
      cyc   = 1'b1;
      stb   = 1'b1;
      we    = write;
      adr   = a;
      datWr = d;
      do begin
         @(posedge clk);
         #2;
         n++;
         if (n > 20) failRun($sformatf("Timeout: no Wishbone ack at word %0d", a));
      end while (!ack);
      q   = datRd;
      cyc = 1'b0;
      stb = 1'b0;
      we  = 1'b0;
   endtask

   task automatic waitStatus(output entryT st);
      int n;
      n = 0;
      do begin
         busCycle(1'b0, AdrStatus, '0, st);
         n++;
         if (n > WaitLimit) failRun("Timeout: neither Done nor ReadErr was set in Status");
      end while (!st[0] && !st[1]);
   endtask

   function automatic entryT expectedEntry(input int s, input int i, input int nData);
      if (i == nData) return Terminator;
      return 32'hC000_0000 | entryT'(s << 16) | entryT'(i);
   endfunction

   task automatic loadScenario(input int s, input scenT sc);
      axiAddrT slotBase;
      int      total;
      slotBase = axiAddrT'(RingBase) + (axiAddrT'(expSlot) << 12);
      total    = sc.nData + sc.hasTerm;
      @(posedge clk);
      #2;
      // Upper 96 bits are junk, only the low word is stored
      for (int i = 0; i < total; i++) begin
         hostMem.mem[slotBase + axiAddrT'(i * 16)] =
            {$urandom, $urandom, $urandom, expectedEntry(s, i, sc.nData)};
      end
      hostMem.mem[axiAddrT'(PtrAddr)]      = axiDataT'(sc.prodSlot) << 12;
      hostMem.mem[axiAddrT'(DoorbellAddr)] = '1;
      rdErrEn   = sc.rdErr;
      rdErrAddr = slotBase + axiAddrT'(sc.errIdx) * 16;
      wrErrEn   = sc.wrErr;
   endtask

   task automatic checkFetch(input int s, input scenT sc);
      entryT   st;
      entryT   word;
      axiDataT db;
      int      cnt;
      slotIdxT nextSlot;
      nextSlot = expSlot + 3'd1;
      cnt      = sc.nData + sc.hasTerm;
      if (cnt > BufDepth) cnt = BufDepth;
      waitStatus(st);
      checkFlag("Done", st[0], 1'b1);
      checkFlag("ReadErr", st[1], 1'b0);
      checkEntry("EntryCount", entryT'(st[15:8]), entryT'(cnt));
      checkSlot("Status consumer slot", st[18:16], nextSlot);
      for (int i = 0; i < cnt; i++) begin
         busCycle(1'b0, AdrWindow + wbAddrT'(i), '0, word);
         checkEntry($sformatf("buffer word %0d", i), word, expectedEntry(s, i, sc.nData));
      end
      db = hostMem.mem[axiAddrT'(DoorbellAddr)];
      checkEntry("doorbell word", db[31:0], {16'h0, 1'b0, nextSlot, 12'h0});
      checkFlag("doorbell write count", (hostMem.wrCount - wrBefore) == (sc.wrErr ? 2 : 1), 1'b1);
   endtask

   task automatic checkQuiet(input bit expErr);
      entryT st;
      // Ten poll periods with margin for the pointer read
      repeat (10 * (PollPeriod + 12)) @(posedge clk);
      busCycle(1'b0, AdrStatus, '0, st);
      checkFlag("Done", st[0], 1'b0);
      checkFlag("ReadErr", st[1], expErr);
      checkSlot("Status consumer slot", st[18:16], expSlot);
      checkFlag("no doorbell write", hostMem.wrCount == wrBefore, 1'b1);
   endtask

   initial begin
      rst_n     = 1'b0;
      cyc       = 1'b0;
      stb       = 1'b0;
      we        = 1'b0;
      adr       = '0;
      datWr     = '0;
      rdErrAddr = '0;
      rdErrEn   = 1'b0;
      wrErrEn   = 1'b0;
      expSlot   = '0;
      void'($urandom(32'h36c2));
      repeat (8) @(posedge clk);
      #2;
      rst_n = 1'b1;

      busCycle(1'b1, 6'd1, PollPeriod, rdVal);
      busCycle(1'b1, 6'd2, RingBase, rdVal);
      busCycle(1'b1, 6'd3, PtrAddr, rdVal);
      busCycle(1'b1, 6'd4, DoorbellAddr, rdVal);
      busCycle(1'b0, 6'd1, '0, rdVal);
      checkEntry("PollPeriod", rdVal, PollPeriod);
      busCycle(1'b0, 6'd2, '0, rdVal);
      checkEntry("RingBase", rdVal, RingBase);
      busCycle(1'b0, 6'd3, '0, rdVal);
      checkEntry("PtrAddr", rdVal, PtrAddr);
      busCycle(1'b0, 6'd4, '0, rdVal);
      checkEntry("DoorbellAddr", rdVal, DoorbellAddr);
      busCycle(1'b0, AdrControl, '0, rdVal);
      checkFlag("enable after reset", rdVal[0], 1'b0);

      for (int s = 0; s < NumScen; s++) begin
         wrBefore = hostMem.wrCount;
         loadScenario(s, Scenarios[s]);
         busCycle(1'b1, AdrStatus, 32'h3, rdVal);
         busCycle(1'b1, AdrControl, 32'h1, rdVal);
         if (Scenarios[s].prodSlot == expSlot) begin
            checkQuiet(1'b0);
         end else if (Scenarios[s].rdErr) begin
            waitStatus(rdVal);
            checkFlag("ReadErr", rdVal[1], 1'b1);
            checkQuiet(1'b1);
         end else begin
            checkFetch(s, Scenarios[s]);
            expSlot = expSlot + 3'd1;
         end
      end

      busCycle(1'b0, AdrControl, '0, rdVal);
      checkFlag("enable", rdVal[0], 1'b1);
      $display("Simulation PASSED");
      $finish;
   end

endmodule

//--- verif/tbClock.sv
`timescale 1ns/1ns

module tbClock #(
   parameter int HalfPeriod = 10
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
   end

   always #HalfPeriod clk = ~clk;

endmodule
